//--- spi_hub_pkg.sv
package spi_hub_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int CMD_WIDTH  = 12;               // full command word.
  localparam int READ_WIDTH = 8;                // captured byte.
  localparam int ADDR_WIDTH = 3;                // slave register address.

  // a read frame only sends the write flag and the address.
  localparam int HDR_WIDTH  = 1 + ADDR_WIDTH;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // field positions inside cmd
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int RW_BIT     = 11;               // 1 = write, 0 = read.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // channel FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    SETUP     = 3'd1,                            // cs falls here.
    SHIFT_OUT = 3'd2,
    SHIFT_IN  = 3'd3,                            // read data phase.
    HOLD      = 3'd4,                            // cs held low after last bit.
    DONE      = 3'd5
  } spi_state_t;

endpackage

//--- spi_cmd_if.sv
`timescale 1ns/1ps

interface spi_cmd_if;
  import spi_hub_pkg::*;

  logic                  start;                  // one cycle, only while idle.
  logic [CMD_WIDTH-1:0]  cmd;
  logic                  busy;
  logic [READ_WIDTH-1:0] rdata;
  logic                  rdone;                  // rdata valid this cycle.

  modport dispatch (
    output start,
    output cmd,
    input  busy
  );

  modport channel (
    input  start,
    input  cmd,
    output busy,
    output rdata,
    output rdone
  );

endinterface

//--- spi_cmd_dispatch.sv
`timescale 1ns/1ps

module spi_cmd_dispatch #(
  parameter int N_CHAN = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [spi_hub_pkg::CMD_WIDTH-1:0] cmd_in,
  input  logic                              cmd_vld,
  input  logic [$clog2(N_CHAN)-1:0]         cmd_chan,
  output logic                              cmd_rdy,
  spi_cmd_if.dispatch                       chan [N_CHAN]
);
  import spi_hub_pkg::*;

  logic [CMD_WIDTH-1:0] cmd_q;
  logic [N_CHAN-1:0]    start_q;
  logic [N_CHAN-1:0]    blocked;
  logic                 chan_ok;
  logic                 accept;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ready decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a start still in flight counts as busy, busy only rises a cycle later.
  for (genvar i = 0; i < N_CHAN; i++)
  begin : g_blk
    assign blocked[i] = chan[i].busy | start_q[i];
  end

  assign chan_ok = (int'(cmd_chan) < N_CHAN);   // guards non power of two.
  assign cmd_rdy = chan_ok & ~blocked[cmd_chan];
  assign accept  = cmd_vld & cmd_rdy;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // start and command registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start_q <= '0;
    end
    else
    begin
      start_q <= '0;
      if (accept)
        start_q[cmd_chan] <= 1'b1;               // addressed channel only.
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
  end

  for (genvar i = 0; i < N_CHAN; i++)
  begin : g_drv
    assign chan[i].start = start_q[i];
    assign chan[i].cmd   = cmd_q;               // shared, only start selects.

    a_start_idle : assert property (
      @(posedge clk) disable iff (!rst_n)
      start_q[i] |-> !chan[i].busy
    );
  end

endmodule

//--- spi_channel.sv
`timescale 1ns/1ps

module spi_channel #(
  parameter int CLK_DIV = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  spi_cmd_if.channel                         ctl,
  output logic                               sclk,
  output logic                               cs,
  output logic                               mosi,
  input  logic                               miso,
  output logic                               rd_vld,
  output logic [spi_hub_pkg::READ_WIDTH-1:0] rd_data,
  input  logic                               rd_ack
);
  import spi_hub_pkg::*;

  localparam int               DIV_W    = $clog2(CLK_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);
  localparam int               BIT_W    = $clog2(CMD_WIDTH);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(CMD_WIDTH - 1);
  localparam logic [BIT_W-1:0] HDR_LAST = BIT_W'(HDR_WIDTH - 1);

  spi_state_t            state;
  logic [DIV_W-1:0]      div_cnt;
  logic [BIT_W-1:0]      bit_cnt;
  logic [CMD_WIDTH-1:0]  sreg;
  logic [READ_WIDTH-1:0] cap;
  logic                  is_wr;
  logic                  rdone_q;
  logic                  in_shift;
  logic                  tick;
  logic                  sclk_rise;
  logic                  bit_end;

  assign in_shift  = (state == SHIFT_OUT) || (state == SHIFT_IN);
  assign tick      = (div_cnt == DIV_LAST);
  assign sclk_rise = in_shift && tick && !sclk;
  assign bit_end   = in_shift && tick && sclk;    // falling sclk closes a bit.

  assign ctl.busy  = (state != IDLE) || rd_vld;   // unclaimed byte blocks.
  assign ctl.rdone = rdone_q;
  assign ctl.rdata = cap;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame FSM, divider and pins
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs      <= 1'b1;
      mosi    <= 1'b0;
      rdone_q <= 1'b0;
    end
    else
    begin
      // last capture lands on this edge, cap is complete next cycle.
      rdone_q <= sclk_rise && (state == SHIFT_IN) && (bit_cnt == LAST_BIT);
      case (state)
        IDLE:
        begin
          div_cnt <= '0;
          bit_cnt <= '0;
          if (ctl.start)
            state <= SETUP;
        end
        SETUP:
        begin
          cs    <= 1'b0;
          mosi  <= sreg[CMD_WIDTH-1];            // first bit, the write flag.
          state <= SHIFT_OUT;
        end
        SHIFT_OUT, SHIFT_IN:
        begin
          div_cnt <= tick ? '0 : div_cnt + 1'b1;
          if (tick)
            sclk <= ~sclk;
          if (bit_end)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            mosi    <= 1'b0;
            if (bit_cnt == LAST_BIT)
              state <= HOLD;
            else if ((state == SHIFT_OUT) && !is_wr && (bit_cnt == HDR_LAST))
              state <= SHIFT_IN;                 // header sent, turn around.
            else if (state == SHIFT_OUT)
              mosi <= sreg[CMD_WIDTH-2];
          end
        end
        HOLD:
        begin
          div_cnt <= tick ? '0 : div_cnt + 1'b1;
          if (tick)
          begin
            cs    <= 1'b1;
            state <= DONE;
          end
        end
        DONE:
        begin
          state <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift, capture and read hand-off
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && ctl.start)
    begin
      sreg  <= ctl.cmd;
      is_wr <= ctl.cmd[RW_BIT];
    end
    else if (bit_end && (state == SHIFT_OUT))
    begin
      sreg <= {sreg[CMD_WIDTH-2:0], 1'b0};
    end
    if (sclk_rise && (state == SHIFT_IN))
      cap <= {cap[READ_WIDTH-2:0], miso};        // msb first.
    if (ctl.rdone)
      rd_data <= ctl.rdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rd_vld <= 1'b0;
    else if (ctl.rdone)
      rd_vld <= 1'b1;
    else if (rd_ack)
      rd_vld <= 1'b0;
  end

  a_cs_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == IDLE) |-> cs
  );

  a_sclk_quiet : assert property (
    @(posedge clk) disable iff (!rst_n)
    (cs && $past(cs)) |-> $stable(sclk)
  );

endmodule

//--- spi_read_collect.sv
`timescale 1ns/1ps

module spi_read_collect #(
  parameter int N_CHAN = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [N_CHAN-1:0]                  rd_vld,
  input  logic [spi_hub_pkg::READ_WIDTH-1:0] rd_data [N_CHAN],
  output logic [N_CHAN-1:0]                  rd_ack,
  output logic                               read_vld,
  output logic [spi_hub_pkg::READ_WIDTH-1:0] read_data,
  output logic [$clog2(N_CHAN)-1:0]          read_chan
);
  import spi_hub_pkg::*;

  localparam int CHAN_W = $clog2(N_CHAN);

  logic [CHAN_W-1:0] last;
  logic [CHAN_W-1:0] sel;
  logic              found;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // round-robin pick
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // search starts one past the last served channel.
  always_comb
  begin
    int idx;
    found = 1'b0;
    sel   = last;
    for (int k = 1; k <= N_CHAN; k++)
    begin
      idx = (int'(last) + k) % N_CHAN;
      // a channel under ack still shows rd_vld for this cycle.
      if (!found && rd_vld[idx] && !rd_ack[idx])
      begin
        found = 1'b1;
        sel   = CHAN_W'(idx);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      last     <= CHAN_W'(N_CHAN - 1);           // channel 0 goes first.
      rd_ack   <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      rd_ack   <= '0;
      read_vld <= found;
      if (found)
      begin
        rd_ack[sel] <= 1'b1;
        last        <= sel;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (found)
    begin
      read_data <= rd_data[sel];
      read_chan <= sel;
    end
  end

  a_ack_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(rd_ack) && ((rd_ack & ~rd_vld) == '0)
  );

endmodule

//--- spi_hub_top.sv
`timescale 1ns/1ps

module spi_hub_top #(
  parameter int N_CHAN  = 4,
  parameter int CLK_DIV = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [spi_hub_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                               cmd_vld,
  input  logic [$clog2(N_CHAN)-1:0]          cmd_chan,
  output logic                               cmd_rdy,
  output logic [N_CHAN-1:0]                  sclk,
  output logic [N_CHAN-1:0]                  cs,
  output logic [N_CHAN-1:0]                  mosi,
  input  logic [N_CHAN-1:0]                  miso,
  output logic                               read_vld,
  output logic [spi_hub_pkg::READ_WIDTH-1:0] read_data,
  output logic [$clog2(N_CHAN)-1:0]          read_chan
);
  import spi_hub_pkg::*;

  logic [N_CHAN-1:0]     rd_vld_w;
  logic [N_CHAN-1:0]     rd_ack_w;
  logic [READ_WIDTH-1:0] rd_data_w [N_CHAN];

  spi_cmd_if chan_if [N_CHAN] ();

  spi_cmd_dispatch #(
    .N_CHAN (N_CHAN)
  ) u_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_chan (cmd_chan),
    .cmd_rdy  (cmd_rdy),
    .chan     (chan_if)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // channel engines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar g = 0; g < N_CHAN; g++)
  begin : g_chan
    spi_channel #(
      .CLK_DIV (CLK_DIV)
    ) u_chan (
      .clk     (clk),
      .rst_n   (rst_n),
      .ctl     (chan_if[g]),
      .sclk    (sclk[g]),
      .cs      (cs[g]),
      .mosi    (mosi[g]),
      .miso    (miso[g]),
      .rd_vld  (rd_vld_w[g]),
      .rd_data (rd_data_w[g]),
      .rd_ack  (rd_ack_w[g])
    );
  end

  spi_read_collect #(
    .N_CHAN (N_CHAN)
  ) u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_vld    (rd_vld_w),
    .rd_data   (rd_data_w),
    .rd_ack    (rd_ack_w),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_chan (read_chan)
  );

endmodule

//--- spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model (
  input  logic        sclk,
  input  logic        cs,
  input  logic        mosi,
  output logic        miso,
  output logic [63:0] regs,
  output int          frames,
  output int          bad_frames
);

  logic [11:0] shreg;
  logic [7:0]  rd_sh;
  logic        is_rd;
  int          rises;

  initial
  begin
    miso       = 1'b0;
    regs       = '0;
    frames     = 0;
    bad_frames = 0;
    shreg      = '0;
    rd_sh      = '0;
    is_rd      = 1'b0;
    rises      = 0;
    forever
    begin
      @(negedge cs);
      rises = 0;
      is_rd = 1'b0;
      while (!cs)
      begin
        @(sclk or cs);
        if (!cs && sclk)
        begin
          shreg = {shreg[10:0], mosi};           // sample on sclk rise.
          rises = rises + 1;
          if ((rises == 4) && !shreg[3])
          begin
            is_rd = 1'b1;
            rd_sh = regs[{shreg[2:0], 3'b000} +: 8];
          end
        end
        else if (!cs && is_rd && (rises >= 4) && (rises < 12))
        begin
          miso  = rd_sh[7];                      // change on sclk fall.
          rd_sh = {rd_sh[6:0], 1'b0};
        end
      end
      frames = frames + 1;
      if (rises != 12)
        bad_frames = bad_frames + 1;
      else if (shreg[11])
        regs[{shreg[10:8], 3'b000} +: 8] = shreg[7:0];
      miso = 1'b0;
    end
  end

endmodule

//--- tb_spi_hub.sv
`timescale 1ns/1ps

module tb_spi_hub;

  localparam int N_CHAN   = 4;
  localparam int CLK_DIV  = 4;
  localparam int HALF_PER = 20;
  localparam int N_VEC    = 64;
  localparam int N_RAND   = 12;
  localparam int MARGIN   = 200;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [11:0] cmd_in;
  logic        cmd_vld;
  logic [1:0]  cmd_chan;
  logic        cmd_rdy;
  logic [3:0]  sclk;
  logic [3:0]  cs;
  logic [3:0]  mosi;
  wire  [3:0]  miso;
  logic        read_vld;
  logic [7:0]  read_data;
  logic [1:0]  read_chan;

  logic [63:0] slv_regs [N_CHAN];
  int          slv_frames [N_CHAN];
  int          slv_bad [N_CHAN];

  logic [27:0] vec [N_VEC];
  logic [7:0]  mirror [N_CHAN][8];
  logic        written [N_CHAN][8];
  int          issued [N_CHAN];
  logic [9:0]  got_q [$];
  integer      seed;
  int          errors;
  int          checks;
  int          n_vec;
  int          cycles = 0;
  int          limit = 32'h7fff_ffff;

  spi_hub_top #(
    .N_CHAN  (N_CHAN),
    .CLK_DIV (CLK_DIV)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_chan  (cmd_chan),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_chan (read_chan)
  );

  for (genvar g = 0; g < N_CHAN; g++)
  begin : g_slv
    spi_slave_model u_slv (
      .sclk       (sclk[g]),
      .cs         (cs[g]),
      .mosi       (mosi[g]),
      .miso       (miso[g]),
      .regs       (slv_regs[g]),
      .frames     (slv_frames[g]),
      .bad_frames (slv_bad[g])
    );
  end

  always #HALF_PER clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= limit)
    begin
      $display("run timed out after %0d clock cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  always @(negedge clk)
  begin
    if ((rst_n === 1'b1) && read_vld)
      got_q.push_back({read_chan, read_data});   // one pulse per byte.
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host side tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // entered and left 2 ns after a rising edge.
  task automatic drive_cmd(input int c, input logic [11:0] cmd, output int waited);
    waited   = 0;
    cmd_chan = 2'(c);
    cmd_in   = cmd;
    cmd_vld  = 1'b1;
    @(negedge clk);
    while (!cmd_rdy)
    begin
      waited = waited + 1;
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    cmd_vld   = 1'b0;
    issued[c] = issued[c] + 1;
    if (cmd[11])
    begin
      mirror[c][cmd[10:8]]  = cmd[7:0];
      written[c][cmd[10:8]] = 1'b1;
    end
  endtask

  task automatic take_read(output int c, output logic [7:0] d);
    logic [9:0] e;
    while (got_q.size() == 0)
      @(negedge clk);
    e = got_q.pop_front();
    c = int'(e[9:8]);
    d = e[7:0];
    @(posedge clk);
    #2;
  endtask

  task automatic check_read(input int c_exp, input logic [7:0] d_exp, input int c_got,
                            input logic [7:0] d_got);
    checks = checks + 1;
    if (c_got != c_exp)
    begin
      errors = errors + 1;
      $display("Fail at %0t: read_chan %0d, expected %0d", $time, c_got, c_exp);
    end
    if (d_got !== d_exp)
    begin
      errors = errors + 1;
      $display("Fail at %0t: chan %0d read_data %h, expected %h", $time, c_exp, d_got, d_exp);
    end
  endtask

  task automatic check_file_exp(input int k);
    int c;
    c = int'(vec[k][23:20]);
    if (vec[k][7:0] !== mirror[c][vec[k][18:16]])
    begin
      errors = errors + 1;
      $display("vector %0d expects %h but the register mirror holds %h", k, vec[k][7:0],
               mirror[c][vec[k][18:16]]);
    end
  endtask

  task automatic report_test(input int n, input int err0);
    if (errors == err0)
      $display("test %0d: ok", n);
    else
      $display("test %0d: %0d errors", n, errors - err0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test groups
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_serial(input int lo, input int hi);
    int         w;
    int         gc;
    logic [7:0] gd;
    for (int k = lo; k < hi; k++)
    begin
      if (!vec[k][19])
        check_file_exp(k);
      drive_cmd(int'(vec[k][23:20]), vec[k][19:8], w);
      if (!vec[k][19])
      begin
        take_read(gc, gd);
        check_read(int'(vec[k][23:20]), vec[k][7:0], gc, gd);
      end
    end
  endtask

  // pairs of a write and a follow-up command to the same channel.
  task automatic run_busy_pair(input int lo, input int hi);
    int         c;
    int         w;
    int         gc;
    logic [7:0] gd;
    for (int k = lo; k + 1 < hi; k += 2)
    begin
      c = int'(vec[k][23:20]);
      drive_cmd(c, vec[k][19:8], w);
      if (!vec[k + 1][19])
        check_file_exp(k + 1);
      drive_cmd(c, vec[k + 1][19:8], w);
      checks = checks + 2;
      if (w == 0)
      begin
        errors = errors + 1;
        $display("Fail at %0t: chan %0d took a command while busy", $time, c);
      end
      if (slv_regs[c][{vec[k][18:16], 3'b000} +: 8] !== vec[k][15:8])
      begin
        errors = errors + 1;
        $display("Fail at %0t: chan %0d ready before its write landed", $time, c);
      end
      if (!vec[k + 1][19])
      begin
        take_read(gc, gd);
        check_read(c, vec[k + 1][7:0], gc, gd);
      end
    end
  endtask

  task automatic run_burst(input int lo, input int hi);
    int          w;
    int          gc;
    logic [7:0]  gd;
    logic [15:0] seen;
    logic        found;
    seen = '0;
    for (int k = lo; k < hi; k++)
    begin
      check_file_exp(k);
      drive_cmd(int'(vec[k][23:20]), vec[k][19:8], w);
    end
    for (int k = lo; k < hi; k++)
    begin
      take_read(gc, gd);
      found = 1'b0;
      for (int m = lo; m < hi; m++)
      begin
        if (!found && !seen[m - lo] && (int'(vec[m][23:20]) == gc))
        begin
          found       = 1'b1;
          seen[m - lo] = 1'b1;
          check_read(gc, vec[m][7:0], gc, gd);
        end
      end
      if (!found)
      begin
        errors = errors + 1;
        $display("Fail at %0t: unexpected byte from chan %0d", $time, gc);
      end
    end
  endtask

  task automatic run_random();
    int         c;
    int         a;
    int         w;
    int         gc;
    logic [7:0] d;
    logic [7:0] gd;
    logic       rd;
    for (int n = 0; n < N_RAND; n++)
    begin
      c  = $random(seed) & 3;
      a  = $random(seed) & 7;
      d  = 8'($random(seed));
      rd = written[c][a] && (($random(seed) & 1) == 1);
      if (rd)
      begin
        drive_cmd(c, {1'b0, 3'(a), 8'h00}, w);
        take_read(gc, gd);
        check_read(c, mirror[c][a], gc, gd);
      end
      else
      begin
        drive_cmd(c, {1'b1, 3'(a), d}, w);
      end
    end
  endtask

  function automatic logic frames_done();
    logic ok;
    ok = (cs == 4'hF);
    for (int c = 0; c < N_CHAN; c++)
    begin
      if (slv_frames[c] != issued[c])
        ok = 1'b0;
    end
    return ok;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    int i;
    int j;
    int t;
    int err0;
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    cmd_chan = '0;
    seed     = 32'he07c_2263;
    errors   = 0;
    checks   = 0;
    for (int c = 0; c < N_CHAN; c++)
    begin
      issued[c] = 0;
      for (int a = 0; a < 8; a++)
      begin
        mirror[c][a]  = 8'h00;                   // slave registers start at zero.
        written[c][a] = 1'b0;
      end
    end
    for (i = 0; i < N_VEC; i++)
      vec[i] = '1;
    $readmemh("spi_tests.mem", vec);
    n_vec = 0;
    while ((n_vec < N_VEC) && (vec[n_vec][27:24] != 4'hF))
      n_vec = n_vec + 1;
    limit = (n_vec + N_RAND) * 30 * CLK_DIV + MARGIN;

    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    err0 = errors;
    @(negedge clk);
    checks = checks + 1;
    if (!cmd_rdy || (cs != 4'hF) || read_vld || (sclk != 4'h0) || (mosi != 4'h0))
    begin
      errors = errors + 1;
      $display("Fail at %0t: idle state rdy %b cs %b vld %b", $time, cmd_rdy, cs, read_vld);
    end
    report_test(1, err0);
    @(posedge clk);
    #2;

    i = 0;
    while (i < n_vec)
    begin
      t    = int'(vec[i][27:24]);
      err0 = errors;
      j    = i;
      while ((j < n_vec) && (int'(vec[j][27:24]) == t))
        j = j + 1;
      if (t == 3)
        run_busy_pair(i, j);
      else if (t == 4)
        run_burst(i, j);
      else
        run_serial(i, j);
      report_test(t, err0);
      i = j;
    end

    err0 = errors;
    run_random();
    report_test(5, err0);

    err0 = errors;
    while (!frames_done())
      @(negedge clk);
    for (int c = 0; c < N_CHAN; c++)
    begin
      checks = checks + 1;
      if (slv_bad[c] != 0)
      begin
        errors = errors + 1;
        $display("Fail at %0t: chan %0d had %0d frames without 12 sclk rises", $time, c,
                 slv_bad[c]);
      end
    end
    checks = checks + 1;
    if (got_q.size() != 0)
    begin
      errors = errors + 1;
      $display("Fail at %0t: %0d read bytes arrived that no command asked for", $time,
               got_q.size());
    end
    report_test(6, err0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- spi_tests.mem
// columns: test, channel, command (3 hex digits), expected read byte
// writes carry 00 in the last column
2093C00
21A5A00
22BC300
23F8100
201003C
212005A
22300C3
2370081
328A700
32000A7
30E1900
3060019
401003C
412005A
42000A7
4370081

//--- list.f
spi_hub_pkg.sv
spi_cmd_if.sv
spi_cmd_dispatch.sv
spi_channel.sv
spi_read_collect.sv
spi_hub_top.sv
spi_slave_model.sv
tb_spi_hub.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_spi_hub -f list.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "test passed" sim.log
then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
